/* logic/hps_cmd_decoder.sv */
// host frame parser driving config, joystick, status and key event outputs and keyboard pushes
`include "hps_io_cfg.svh"

module hps_cmd_decoder
	import hps_cmd_pkg::*;
	import ps2_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 io_enable,
	input  logic                 io_strobe,
	input  hps_word_t            io_din,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,
	output logic [`JOY_W-1:0]    joystick_0,
	output logic [`JOY_W-1:0]    joystick_1,
	output logic [`STATUS_W-1:0] status,
	output ps2_key_t             ps2_key,
	output ps2_byte_t            kbd_byte,
	output logic                 kbd_push
);

	hps_cmd_e    cmd;
	word_cnt_t   word_cnt;
	logic        kbd_skip;
	hps_word_t   cfg;
	logic [31:0] key_raw;
	logic        key_pressed;
	logic        key_extended;
	ps2_key_t    key_next;
	logic        kbd_accept;

	// config bit fields
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// keyboard payload word that feeds the FIFO and the raw shifter
	assign kbd_accept = io_enable && io_strobe && (word_cnt != '0) &&
		(cmd == CMD_PS2_KBD) && !(&io_din[15:8]) && !kbd_skip;

	//////////////////////////////////////////////////
	// key event from the last raw bytes
	//////////////////////////////////////////////////

	always_comb begin
		key_pressed = (key_raw[15:8] != PS2_BREAK);
		// a release puts F0 between the E0 prefix and the code
		if (key_pressed) begin
			key_extended = (key_raw[15:8] == PS2_EXT);
		end else begin
			key_extended = (key_raw[23:16] == PS2_EXT);
		end
		key_next = {~ps2_key[10], key_pressed, key_extended, key_raw[7:0]};
		case (key_raw)
			PRNSCR_MAKE:  key_next[9:0] = PRNSCR_MAKE_KEY;
			PRNSCR_BREAK: key_next[9:0] = PRNSCR_BREAK_KEY;
			PAUSE_MAKE:   key_next[9:0] = PAUSE_MAKE_KEY;
			default:      key_next[9:0] = key_next[9:0];
		endcase
	end

	// newest byte in [7:0], cleared by the keyboard command word
	always_ff @(posedge clk_sys) begin
		if (io_enable && io_strobe && (word_cnt == '0) && (io_din == CMD_PS2_KBD)) begin
			key_raw <= '0;
		end else if (kbd_accept) begin
			key_raw <= {key_raw[23:0], io_din[7:0]};
		end
	end

	//////////////////////////////////////////////////
	// frame parser
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd        <= CMD_NONE;
			word_cnt   <= '0;
			kbd_skip   <= 1'b0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			ps2_key    <= '0;
			kbd_byte   <= '0;
			kbd_push   <= 1'b0;
		end else begin
			kbd_push <= 1'b0;
			if (!io_enable) begin
				// end of frame, publish the key event once
				if ((cmd == CMD_PS2_KBD) && !kbd_skip) begin
					ps2_key <= key_next;
				end
				cmd      <= CMD_NONE;
				word_cnt <= '0;
				kbd_skip <= 1'b0;
			end else if (io_strobe) begin
				if (word_cnt != '1) begin
					word_cnt <= word_cnt + 1'b1;
				end
				if (word_cnt == '0) begin
					cmd <= hps_cmd_e'(io_din);
				end else begin
					case (cmd)
						CMD_CFG: begin
							if (word_cnt == 1) begin
								cfg <= io_din;
							end
						end
						CMD_JOY0: begin
							if (word_cnt == 1) begin
								joystick_0[15:0] <= io_din;
							end else begin
								joystick_0[`JOY_W-1:16] <= io_din;
							end
						end
						CMD_JOY1: begin
							if (word_cnt == 1) begin
								joystick_1[15:0] <= io_din;
							end else begin
								joystick_1[`JOY_W-1:16] <= io_din;
							end
						end
						CMD_STATUS: begin
							// quarters low first, extra words ignored
							case (word_cnt)
								4'd1:    status[15:0]  <= io_din;
								4'd2:    status[31:16] <= io_din;
								4'd3:    status[47:32] <= io_din;
								4'd4:    status[63:48] <= io_din;
								default: status        <= status;
							endcase
						end
						CMD_PS2_KBD: begin
							// FF in the high byte drops the rest of the frame
							if (&io_din[15:8]) begin
								kbd_skip <= 1'b1;
							end else if (!kbd_skip) begin
								kbd_byte <= io_din[7:0];
								kbd_push <= 1'b1;
							end
						end
						default: begin
							cmd <= cmd;
						end
					endcase
				end
			end
		end
	end

endmodule

/* logic/hps_cmd_pkg.sv */
// host command opcodes, bus word and payload counter types
`include "hps_io_cfg.svh"

package hps_cmd_pkg;

	//////////////////////////////////////////////////
	// bus word
	//////////////////////////////////////////////////

	typedef logic [`HPS_WORD_W-1:0] hps_word_t;

	// payload word number, saturates at its maximum
	typedef logic [3:0] word_cnt_t;

	//////////////////////////////////////////////////
	// command opcodes
	//////////////////////////////////////////////////

	// first strobed word of a frame
	typedef enum logic [15:0] {
		CMD_NONE    = 16'h0000,
		CMD_CFG     = 16'h0001,
		CMD_JOY0    = 16'h0002,
		CMD_JOY1    = 16'h0003,
		CMD_PS2_KBD = 16'h0005,
		CMD_STATUS  = 16'h001E
	} hps_cmd_e;

endpackage

/* logic/hps_io_cfg.svh */
// width, FIFO depth and PS/2 timing macros for the host I/O bridge
`ifndef HPS_IO_CFG_SVH
`define HPS_IO_CFG_SVH

//////////////////////////////////////////////////
// host bus and output widths
//////////////////////////////////////////////////

// one host bus word
`define HPS_WORD_W 16

// joystick and status registers
`define JOY_W 32
`define STATUS_W 64

// toggle, pressed, extended, 8-bit code
`define KEY_W 11

//////////////////////////////////////////////////
// PS/2 keyboard emulation
//////////////////////////////////////////////////

// address bits of the keyboard byte FIFO, depth 16
`define PS2_FIFO_BITS 4

// clk_sys cycles per half period of the PS/2 clock
`define PS2_CLK_DIV 4

// idle PS/2 clock rising edges before a frame may start
`define PS2_IDLE_WAIT 4

`endif

/* logic/hps_io_top.sv */
// top level of the host I/O bridge: decoder, keyboard FIFO and PS/2 serializer
`include "hps_io_cfg.svh"

module hps_io_top
	import hps_cmd_pkg::*;
	import ps2_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 io_enable,
	input  logic                 io_strobe,
	input  hps_word_t            io_din,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,
	output logic [`JOY_W-1:0]    joystick_0,
	output logic [`JOY_W-1:0]    joystick_1,
	output logic [`STATUS_W-1:0] status,
	output ps2_key_t             ps2_key,
	output logic                 ps2_kbd_clk_out,
	output logic                 ps2_kbd_data_out,
	input  logic                 ps2_kbd_clk_in,
	input  logic                 ps2_kbd_data_in
);

	// decoder to FIFO
	logic      kbd_push;
	ps2_byte_t kbd_byte;

	// FIFO to serializer
	logic      fifo_pop;
	logic      fifo_valid;
	ps2_byte_t fifo_data;

	hps_cmd_decoder u_decoder (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.kbd_byte           (kbd_byte),
		.kbd_push           (kbd_push)
	);

	ps2_tx_fifo u_fifo (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.kbd_push   (kbd_push),
		.kbd_byte   (kbd_byte),
		.fifo_pop   (fifo_pop),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data)
	);

	ps2_kbd_serializer u_serializer (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.fifo_valid       (fifo_valid),
		.fifo_data        (fifo_data),
		.ps2_kbd_clk_in   (ps2_kbd_clk_in),
		.ps2_kbd_data_in  (ps2_kbd_data_in),
		.fifo_pop         (fifo_pop),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

/* logic/ps2_kbd_serializer.sv */
// PS/2 clock divider and device-side frame transmitter with bus idle wait
`include "hps_io_cfg.svh"

module ps2_kbd_serializer
	import ps2_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      fifo_valid,
	input  ps2_byte_t fifo_data,
	input  logic      ps2_kbd_clk_in,
	input  logic      ps2_kbd_data_in,
	output logic      fifo_pop,
	output logic      ps2_kbd_clk_out,
	output logic      ps2_kbd_data_out
);

	localparam int DIV_W  = $clog2(`PS2_CLK_DIV + 1);
	localparam int WAIT_W = $clog2(`PS2_IDLE_WAIT + 1);

	logic [DIV_W-1:0]  div_cnt;
	logic              ps2_clk;
	logic              rise_tick;
	logic              fall_tick;
	logic [1:0]        clk_sync;
	logic [1:0]        data_sync;
	logic [WAIT_W-1:0] idle_cnt;
	ps2_tx_state_e     state;
	ps2_byte_t         tx_byte;
	logic [2:0]        bit_cnt;
	logic              bus_idle;
	logic              start_tx;

	//////////////////////////////////////////////////
	// PS/2 clock and input sync
	//////////////////////////////////////////////////

	// ticks land one cycle after the internal clock toggles
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt   <= '0;
			ps2_clk   <= 1'b0;
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
		end else begin
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
			if (div_cnt == DIV_W'(`PS2_CLK_DIV - 1)) begin
				div_cnt   <= '0;
				ps2_clk   <= ~ps2_clk;
				rise_tick <= ~ps2_clk;
				fall_tick <= ps2_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_kbd_clk_in};
			data_sync <= {data_sync[0], ps2_kbd_data_in};
		end
	end

	// host leaves both lines high and there is something to send
	assign bus_idle = clk_sync[1] && data_sync[1] && fifo_valid;
	assign start_tx = rise_tick && (state == TX_IDLE) && bus_idle &&
		(idle_cnt == WAIT_W'(`PS2_IDLE_WAIT - 1));
	assign fifo_pop = start_tx;

	always_ff @(posedge clk_sys) begin
		if (start_tx) begin
			tx_byte <= fifo_data;
		end
	end

	//////////////////////////////////////////////////
	// frame transmitter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state            <= TX_IDLE;
			idle_cnt         <= '0;
			bit_cnt          <= '0;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else if (rise_tick) begin
			ps2_kbd_clk_out <= 1'b1;
			case (state)
				TX_IDLE: begin
					if (!bus_idle) begin
						idle_cnt <= '0;
					end else if (start_tx) begin
						idle_cnt         <= '0;
						bit_cnt          <= '0;
						ps2_kbd_data_out <= 1'b0;
						state            <= TX_DATA;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				TX_DATA: begin
					// lsb first, bit_cnt wraps back to zero after bit 7
					ps2_kbd_data_out <= tx_byte[bit_cnt];
					bit_cnt          <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) begin
						state <= TX_PARITY;
					end
				end
				TX_PARITY: begin
					ps2_kbd_data_out <= ~^tx_byte;
					state            <= TX_STOP;
				end
				TX_STOP: begin
					// first rise drives stop, second one ends the frame
					if (bit_cnt == 3'd0) begin
						ps2_kbd_data_out <= 1'b1;
						bit_cnt          <= 3'd1;
					end else begin
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end else if (fall_tick) begin
			// clock pulses low only while a frame is on the wire
			ps2_kbd_clk_out <= (state == TX_IDLE);
		end
	end

endmodule

/* logic/ps2_pkg.sv */
// PS/2 byte, key event and transmit state types with prefix and special scan codes
`include "hps_io_cfg.svh"

package ps2_pkg;

	typedef logic [7:0] ps2_byte_t;

	// [10] toggle, [9] pressed, [8] extended, [7:0] code
	typedef logic [`KEY_W-1:0] ps2_key_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

	// scan code prefixes
	localparam ps2_byte_t PS2_BREAK = 8'hF0;
	localparam ps2_byte_t PS2_EXT   = 8'hE0;

	// multi-byte sequences that map to a single key event
	localparam logic [31:0] PRNSCR_MAKE      = 32'hE012E07C;
	localparam logic [9:0]  PRNSCR_MAKE_KEY  = 10'h37C;
	localparam logic [31:0] PRNSCR_BREAK     = 32'h7CE0F012;
	localparam logic [9:0]  PRNSCR_BREAK_KEY = 10'h17C;
	localparam logic [31:0] PAUSE_MAKE       = 32'hF014F077;
	localparam logic [9:0]  PAUSE_MAKE_KEY   = 10'h377;

endpackage

/* logic/ps2_tx_fifo.sv */
// register FIFO holding keyboard bytes for the PS/2 serializer
`include "hps_io_cfg.svh"

module ps2_tx_fifo
	import ps2_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      kbd_push,
	input  ps2_byte_t kbd_byte,
	input  logic      fifo_pop,
	output logic      fifo_valid,
	output ps2_byte_t fifo_data
);

	localparam int DEPTH = 1 << `PS2_FIFO_BITS;

	ps2_byte_t mem [DEPTH];

	// extra msb tells full from empty
	logic [`PS2_FIFO_BITS:0] wr_ptr;
	logic [`PS2_FIFO_BITS:0] rd_ptr;
	logic                    full;
	logic                    wr_en;

	assign full = (wr_ptr[`PS2_FIFO_BITS] != rd_ptr[`PS2_FIFO_BITS]) &&
		(wr_ptr[`PS2_FIFO_BITS-1:0] == rd_ptr[`PS2_FIFO_BITS-1:0]);
	assign wr_en      = kbd_push && !full;
	assign fifo_valid = (wr_ptr != rd_ptr);
	assign fifo_data  = mem[rd_ptr[`PS2_FIFO_BITS-1:0]];

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_ptr[`PS2_FIFO_BITS-1:0]] <= kbd_byte;
		end
	end

	// a byte pushed while full is lost
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (fifo_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* sim.f */
+incdir+logic
logic/hps_cmd_pkg.sv
logic/ps2_pkg.sv
logic/hps_cmd_decoder.sv
logic/ps2_tx_fifo.sv
logic/ps2_kbd_serializer.sv
logic/hps_io_top.sv
verification/hps_io_asserts.sv
verification/hps_io_checker.sv
verification/hps_io_tb.sv

/* verification/hps_io_asserts.sv */
// concurrent assertions on the bridge top level for FIFO pop, PS/2 data and push after reset
module hps_io_asserts (
	input logic clk_sys,
	input logic rst_n,
	input logic kbd_push,
	input logic fifo_pop,
	input logic fifo_valid,
	input logic ps2_kbd_clk_out,
	input logic ps2_kbd_data_out
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of failed assertions
	int assert_fails = 0;

	// serializer pops only a non-empty FIFO
	pop_needs_data: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fifo_pop |-> fifo_valid)
		else begin
			$error("fifo_pop while the FIFO is empty");
			assert_fails++;
		end

	// device data holds through the low phase of the PS/2 clock
	data_stable_low: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!ps2_kbd_clk_out && !$past(ps2_kbd_clk_out)) |-> $stable(ps2_kbd_data_out))
		else begin
			$error("ps2_kbd_data_out changed while ps2_kbd_clk_out was low");
			assert_fails++;
		end

	no_push_after_reset: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> !kbd_push)
		else begin
			$error("kbd_push high in the first cycle after reset");
			assert_fails++;
		end

endmodule

bind hps_io_top hps_io_asserts u_asserts (.*);

/* verification/hps_io_checker.sv */
// reference model of the bridge, output comparison, PS/2 frame decoding and per-test report
`include "hps_io_cfg.svh"

module hps_io_checker
	import hps_cmd_pkg::*;
	import ps2_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 io_enable,
	input  logic                 io_strobe,
	input  hps_word_t            io_din,
	input  logic [1:0]           buttons,
	input  logic                 forced_scandoubler,
	input  logic                 direct_video,
	input  logic [`JOY_W-1:0]    joystick_0,
	input  logic [`JOY_W-1:0]    joystick_1,
	input  logic [`STATUS_W-1:0] status,
	input  ps2_key_t             ps2_key,
	input  logic                 ps2_kbd_clk_out,
	input  logic                 ps2_kbd_data_out,
	input  logic                 ps2_kbd_clk_in,
	input  logic                 test_end,
	input  int                   test_id,
	output int                   pending,
	output int                   errors,
	output int                   tests_failed
);
	timeunit 1ns;
	timeprecision 100ps;

	hps_word_t            m_cmd = CMD_NONE;
	logic [3:0]           m_word = '0;
	logic                 m_skip = 1'b0;
	hps_word_t            m_cfg = '0;
	logic [`JOY_W-1:0]    m_joy0 = '0;
	logic [`JOY_W-1:0]    m_joy1 = '0;
	logic [`STATUS_W-1:0] m_status = '0;
	ps2_key_t             m_key = '0;
	logic [31:0]          m_raw = '0;
	ps2_byte_t            exp_bytes [256];
	int                   n_pushed = 0;
	int                   n_sent = 0;
	logic [10:0]          frame = '0;
	int                   n_bits = 0;
	logic                 clk_out_q = 1'b1;
	int                   err_cnt = 0;
	int                   fail_cnt = 0;
	int                   err_at_start = 0;

	assign pending      = n_pushed - n_sent;
	assign errors       = err_cnt;
	assign tests_failed = fail_cnt;

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic fail(input string what);
		err_cnt++;
		$display("%s", what);
	endtask

	// key event from toggle, pressed, extended and code with the special sequences on top
	function automatic ps2_key_t key_event(input logic [31:0] raw, input logic toggle);
		logic     pressed;
		logic     ext;
		ps2_key_t key;
		pressed = (raw[15:8] != PS2_BREAK);
		ext     = pressed ? (raw[15:8] == PS2_EXT) : (raw[23:16] == PS2_EXT);
		key     = {~toggle, pressed, ext, raw[7:0]};
		if (raw == PRNSCR_MAKE)
			key[9:0] = PRNSCR_MAKE_KEY;
		if (raw == PRNSCR_BREAK)
			key[9:0] = PRNSCR_BREAK_KEY;
		if (raw == PAUSE_MAKE)
			key[9:0] = PAUSE_MAKE_KEY;
		return key;
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1:       return "config";
			2:       return "joysticks";
			3:       return "status";
			4:       return "key events";
			5:       return "ps2 frames";
			default: return "host inhibit";
		endcase
	endfunction

	// frame bits land start first and give [0] start, [8:1] data, [9] parity and [10] stop
	task automatic check_frame();
		if (pending == 0) begin
			fail("PS/2 frame sent while no keyboard byte was queued");
		end else begin
			if (frame[0] !== 1'b0)
				fail("PS/2 frame start bit is not low");
			if (frame[10] !== 1'b1)
				fail("PS/2 frame stop bit is not high");
			if ((^frame[9:1]) !== 1'b1)
				fail("PS/2 frame parity is not odd");
			compare("ps2_kbd_data_out", exp_bytes[n_sent], frame[8:1]);
			n_sent++;
		end
	endtask

	//////////////////////////////////////////////////
	// compare first and advance the model by one cycle after
	//////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (rst_n) begin
			compare("buttons", m_cfg[1:0], buttons);
			compare("forced_scandoubler", m_cfg[4], forced_scandoubler);
			compare("direct_video", m_cfg[10], direct_video);
			compare("joystick_0", m_joy0, joystick_0);
			compare("joystick_1", m_joy1, joystick_1);
			compare("status", m_status, status);
			compare("ps2_key", m_key, ps2_key);
			// host holds the clock low
			if (!ps2_kbd_clk_in && ((ps2_kbd_clk_out !== 1'b1) || (ps2_kbd_data_out !== 1'b1)))
				fail("PS/2 outputs left idle high state while the host inhibits the bus");
			if (clk_out_q && !ps2_kbd_clk_out) begin
				frame = {ps2_kbd_data_out, frame[10:1]};
				n_bits++;
				if (n_bits == 11) begin
					check_frame();
					n_bits = 0;
				end
			end
			clk_out_q = ps2_kbd_clk_out;

			if (!io_enable) begin
				if ((m_cmd == CMD_PS2_KBD) && !m_skip)
					m_key = key_event(m_raw, m_key[10]);
				m_cmd  = CMD_NONE;
				m_word = '0;
				m_skip = 1'b0;
			end else if (io_strobe) begin
				if (m_word == 0) begin
					m_cmd = io_din;
					if (io_din == CMD_PS2_KBD)
						m_raw = '0;
				end else begin
					case (m_cmd)
						CMD_CFG: begin
							if (m_word == 1)
								m_cfg = io_din;
						end
						CMD_JOY0: begin
							if (m_word == 1)
								m_joy0[15:0] = io_din;
							else
								m_joy0[31:16] = io_din;
						end
						CMD_JOY1: begin
							if (m_word == 1)
								m_joy1[15:0] = io_din;
							else
								m_joy1[31:16] = io_din;
						end
						CMD_STATUS: begin
							if (m_word <= 4)
								m_status[16*(m_word-1) +: 16] = io_din;
						end
						CMD_PS2_KBD: begin
							if (io_din[15:8] == 8'hFF) begin
								m_skip = 1'b1;
							end else if (!m_skip) begin
								exp_bytes[n_pushed] = io_din[7:0];
								n_pushed++;
								m_raw = {m_raw[23:0], io_din[7:0]};
							end
						end
						default: ;
					endcase
				end
				if (m_word != 4'hF)
					m_word++;
			end

			if (test_end) begin
				if (err_cnt != err_at_start)
					fail_cnt++;
				$display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
					(err_cnt == err_at_start) ? "ok" : "failed", err_cnt - err_at_start);
				err_at_start = err_cnt;
			end
		end
	end

endmodule

/* verification/hps_io_tb.sv */
// testbench top for the host I/O bridge with clock, reset, random frames, checker and timeout
`include "hps_io_cfg.svh"

module hps_io_tb
	import hps_cmd_pkg::*;
	import ps2_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// worst case words, frames and PS/2 bytes over all six tests
	localparam int WORDS    = 16 + 24 + 30 + 48 + 15 + 8 + 18 + 7;
	localparam int FRAMES   = 8 + 8 + 6 + 17 + 2 + 1;
	localparam int BYTES    = 36 + 12 + 2 + 13 + 6;
	// idle wait, 11 bits and clock phase per byte
	localparam int BYTE_CYC = 2 * `PS2_CLK_DIV * (11 + `PS2_IDLE_WAIT + 2);
	localparam int HOLD_CYC = 4 * `PS2_CLK_DIV * (11 + `PS2_IDLE_WAIT);
	localparam int CYCLE_LIMIT = 8 + 4 * WORDS + 3 * FRAMES + 12 + BYTES * BYTE_CYC +
		HOLD_CYC + 200;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 io_enable;
	logic                 io_strobe;
	hps_word_t            io_din;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	logic                 direct_video;
	logic [`JOY_W-1:0]    joystick_0;
	logic [`JOY_W-1:0]    joystick_1;
	logic [`STATUS_W-1:0] status;
	ps2_key_t             ps2_key;
	logic                 ps2_kbd_clk_out;
	logic                 ps2_kbd_data_out;
	logic                 ps2_kbd_clk_in;
	logic                 ps2_kbd_data_in;
	logic                 test_end;
	int                   test_id;
	int                   pending;
	int                   errors;
	int                   tests_failed;
	int                   cycles;
	hps_word_t            frame_q [$];

	hps_io_top UUT (.*);

	hps_io_checker u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// one frame from frame_q with random gaps after each strobe
	task automatic send_frame();
		io_enable = 1'b1;
		while (frame_q.size() > 0) begin
			io_strobe = 1'b1;
			io_din    = frame_q.pop_front();
			next_cycle();
			io_strobe = 1'b0;
			repeat ($urandom_range(3, 0)) next_cycle();
		end
		io_enable = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic wait_drain();
		while (pending != 0)
			next_cycle();
	endtask

	task automatic end_test(input int id);
		test_id  = id;
		test_end = 1'b1;
		next_cycle();
		test_end = 1'b0;
	endtask

	// make, break, extended make or extended break of a random code
	task automatic queue_key();
		int kind;
		kind = $urandom_range(3, 0);
		frame_q.push_back(CMD_PS2_KBD);
		if (kind[1])
			frame_q.push_back(16'h00E0);
		if (kind[0])
			frame_q.push_back(16'h00F0);
		frame_q.push_back(16'($urandom_range(16'h7F, 16'h01)));
	endtask

	task automatic queue_seq(input logic [31:0] seq);
		frame_q.push_back(CMD_PS2_KBD);
		for (int i = 3; i >= 0; i--)
			frame_q.push_back({8'h00, seq[i*8 +: 8]});
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(23536));
		rst_n           = 1'b0;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		ps2_kbd_clk_in  = 1'b1;
		ps2_kbd_data_in = 1'b1;
		test_end        = 1'b0;
		test_id         = 0;
		repeat (8) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		next_cycle();

		repeat (8) begin
			frame_q.push_back(CMD_CFG);
			frame_q.push_back(16'($urandom));
			send_frame();
		end
		end_test(1);

		repeat (8) begin
			frame_q.push_back($urandom_range(1, 0) ? CMD_JOY1 : CMD_JOY0);
			frame_q.push_back(16'($urandom));
			frame_q.push_back(16'($urandom));
			send_frame();
		end
		end_test(2);

		repeat (6) begin
			frame_q.push_back(CMD_STATUS);
			repeat (4) frame_q.push_back(16'($urandom));
			send_frame();
		end
		end_test(3);

		// drain after each frame so the FIFO never overflows
		repeat (12) begin
			queue_key();
			send_frame();
			wait_drain();
		end
		queue_seq(PRNSCR_MAKE);
		send_frame();
		queue_seq(PRNSCR_BREAK);
		send_frame();
		queue_seq(PAUSE_MAKE);
		send_frame();
		wait_drain();
		repeat (2) begin
			frame_q.push_back(CMD_PS2_KBD);
			frame_q.push_back(16'($urandom_range(16'h7F, 16'h01)));
			frame_q.push_back(16'hFF00);
			frame_q.push_back(16'h0012);
			send_frame();
			wait_drain();
		end
		end_test(4);

		// two bursts with the second one skipped from its sixth byte
		for (int f = 0; f < 2; f++) begin
			frame_q.push_back(CMD_PS2_KBD);
			for (int i = 0; i < 8; i++)
				frame_q.push_back((f == 1 && i == 5) ? 16'hFF5A : {8'h00, 8'($urandom)});
			send_frame();
		end
		wait_drain();
		end_test(5);

		while (!ps2_kbd_clk_out)
			next_cycle();
		ps2_kbd_clk_in = 1'b0;
		frame_q.push_back(CMD_PS2_KBD);
		repeat (6) frame_q.push_back({8'h00, 8'($urandom)});
		send_frame();
		repeat (HOLD_CYC) next_cycle();
		ps2_kbd_clk_in = 1'b1;
		wait_drain();
		end_test(6);

		$display("tests run 6, failed %0d, errors %0d, assertion failures %0d",
			tests_failed, errors, UUT.u_asserts.assert_fails);
		if (errors == 0 && tests_failed == 0 && UUT.u_asserts.assert_fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles <= CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

endmodule
